/* Bender.yml */
package:
  name: keypad_entry

sources:
  - keypad_pkg.sv
  - display_pkg.sv
  - keypad_scanner.sv
  - digit_entry.sv
  - bin_converter.sv
  - seg_display.sv
  - keypad_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - keypad_checker.sv
      - tb_keypad_top.sv

/* bin_converter.sv */
`timescale 1ns/1ps

module bin_converter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  display_pkg::bcd_digits_t  digits_i,
    output display_pkg::bin_value_t   value_o
);
    import display_pkg::*;

    bcd_digits_t digit_q;   // remaining digits, next one in the top nibble
    bin_value_t  acc;
    bin_value_t  step_sum;
    logic [1:0]  step_cnt;
    logic        busy;

    // one horner step
    function automatic bin_value_t mul10_add(bin_value_t sum, logic [3:0] d);
        return sum * 16'd10 + bin_value_t'(d);
    endfunction

    assign step_sum = mul10_add(acc, digit_q[ENTRY_DIGITS*4-1 -: 4]);

    // control, a new start always wins
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            value_o  <= '0;
        end else if (start_i) begin
            busy     <= 1'b1;
            step_cnt <= 2'd1;  // first digit folded in at capture
        end else if (busy) begin
            if (step_cnt == 2'(ENTRY_DIGITS - 1)) begin
                busy    <= 1'b0;
                value_o <= step_sum;  // result only at completion
            end else begin
                step_cnt <= step_cnt + 2'd1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc     <= mul10_add('0, digits_i[ENTRY_DIGITS*4-1 -: 4]);
            digit_q <= digits_i << 4;
        end else if (busy) begin
            acc     <= step_sum;
            digit_q <= digit_q << 4;
        end
    end

endmodule

/* digit_entry.sv */
`timescale 1ns/1ps

module digit_entry (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      key_valid_i,
    input  keypad_pkg::key_code_t     key_code_i,
    output display_pkg::bcd_digits_t  digits_o,
    output logic                      update_o
);
    import keypad_pkg::*;
    import display_pkg::*;

    bcd_digits_t digits_next;
    logic        is_digit;

    assign is_digit = (key_code_i <= 4'd9);  // letter keys fall through

    always_comb begin
        digits_next = digits_o;
        if (key_valid_i) begin
            if (is_digit) begin
                // oldest digit drops off the top
                digits_next = {digits_o[(ENTRY_DIGITS-1)*4-1:0], key_code_i};
            end else if (key_code_i == KEY_CLEAR) begin
                digits_next = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digits_o <= '0;
            update_o <= 1'b0;
        end else begin
            digits_o <= digits_next;
            update_o <= (digits_next != digits_o);  // only on a real change
        end
    end

endmodule

/* display_pkg.sv */
package display_pkg;

    localparam int ENTRY_DIGITS       = 4;
    localparam int NUM_DISPLAY_DIGITS = 8;

    // digit 0 holds the most recent key
    typedef logic [ENTRY_DIGITS*4-1:0] bcd_digits_t;
    typedef logic [15:0]               bin_value_t;

    // segment a in bit 0 up to segment g in bit 6, active high
    typedef logic [6:0]                      seg_t;
    typedef logic [NUM_DISPLAY_DIGITS*7-1:0] seg_bus_t;

    localparam seg_t HEX_GLYPH [16] = '{
        7'h3F,  // 0
        7'h06,  // 1
        7'h5B,  // 2
        7'h4F,  // 3
        7'h66,  // 4
        7'h6D,  // 5
        7'h7D,  // 6
        7'h07,  // 7
        7'h7F,  // 8
        7'h6F,  // 9
        7'h77,  // A
        7'h7C,  // b
        7'h39,  // C
        7'h5E,  // d
        7'h79,  // E
        7'h71   // F
    };

endpackage

/* files.f */
keypad_pkg.sv
display_pkg.sv
keypad_scanner.sv
digit_entry.sv
bin_converter.sv
seg_display.sv
keypad_top.sv
tb_clock_gen.sv
keypad_checker.sv
tb_keypad_top.sv

/* keypad_checker.sv */
`timescale 1ns/1ps

module keypad_checker (
    input logic                     clk,
    input logic                     rst,
    input keypad_pkg::row_t         rows_i,
    input logic                     key_valid_i,
    input logic                     update_i,
    input display_pkg::bin_value_t  value_i,
    input display_pkg::bcd_digits_t digits_i,
    input display_pkg::seg_bus_t    seg_i
);
    import keypad_pkg::*;
    import display_pkg::*;

    int unsigned assert_fails = 0;  // read by the testbench at the end

    // exactly one row driven low at any time
    a_one_row: assert property (@(posedge clk) disable iff (rst) $onehot(~rows_i))
        else begin
            assert_fails++;
            $error("rows_o does not have exactly one low row");
        end

    a_strobe: assert property (@(posedge clk) disable iff (rst) key_valid_i |=> !key_valid_i)
        else begin
            assert_fails++;
            $error("key_valid_o stayed high for two cycles");
        end

    a_update: assert property (@(posedge clk) disable iff (rst) update_i |-> $past(key_valid_i))
        else begin
            assert_fails++;
            $error("update_o fired without a key strobe the cycle before");
        end

    // display register follows its inputs by one cycle
    a_seg: assert property (@(posedge clk) disable iff (rst)
        $changed(seg_i) |-> ($past(value_i) != $past(value_i, 2)) ||
                            ($past(digits_i) != $past(digits_i, 2)))
        else begin
            assert_fails++;
            $error("seg_o changed without a change of value or digits");
        end

endmodule

bind keypad_top keypad_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .rows_i      (rows_o),
    .key_valid_i (key_valid),
    .update_i    (update),
    .value_i     (value),
    .digits_i    (digits),
    .seg_i       (seg_o)
);

/* keypad_pkg.sv */
package keypad_pkg;

    // matrix keypad signal types
    typedef logic [3:0] row_t;       // active low row drive
    typedef logic [3:0] col_t;       // active high column sense
    typedef logic [3:0] key_code_t;

    localparam int NUM_ROWS    = 4;
    localparam int SCAN_DIVIDE = 480;  // clocks per row

    localparam row_t      ROW_FIRST = 4'b1110;  // row 0 driven first
    localparam key_code_t KEY_CLEAR = 4'hE;

    // indexed by {row, column}, column 0 is bit 0 of the column bus
    localparam key_code_t KEY_MAP [16] = '{
        4'h1, 4'h2, 4'h3, 4'hA,   // row 0
        4'h4, 4'h5, 4'h6, 4'hB,   // row 1
        4'h7, 4'h8, 4'h9, 4'hC,   // row 2
        4'hE, 4'h0, 4'hF, 4'hD    // row 3
    };

endpackage

/* keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner (
    input  logic                  clk,
    input  logic                  rst,
    input  keypad_pkg::col_t      columns_i,
    output keypad_pkg::row_t      rows_o,
    output logic                  key_valid_o,
    output keypad_pkg::key_code_t key_code_o
);
    import keypad_pkg::*;

    logic [$clog2(SCAN_DIVIDE)-1:0] div_cnt;
    logic [$clog2(NUM_ROWS)-1:0]    row_idx;   // tracks the low bit of rows_o
    logic [NUM_ROWS-1:0]            held_q;    // key still down in that row
    logic [1:0]                     col_idx;
    logic [2:0]                     col_count;
    logic                           row_end;
    logic                           single_hit;
    logic                           no_hit;
    logic                           press;

    assign row_end = (div_cnt == SCAN_DIVIDE - 1);

    // count the high columns and remember which one
    always_comb begin
        col_idx   = '0;
        col_count = '0;
        for (int c = 0; c < $bits(col_t); c++) begin
            if (columns_i[c]) begin
                col_idx   = c[1:0];
                col_count = col_count + 3'd1;
            end
        end
    end

    assign single_hit = (col_count == 3'd1);
    assign no_hit     = (columns_i == '0);

    // new key only if this row was idle at its last sample
    assign press = row_end && single_hit && !held_q[row_idx];

    // row timing and rotation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            row_idx <= '0;
            rows_o  <= ROW_FIRST;
        end else if (row_end) begin
            div_cnt <= '0;
            row_idx <= row_idx + 1'b1;  // wraps after row 3
            rows_o  <= {rows_o[NUM_ROWS-2:0], rows_o[NUM_ROWS-1]};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // held flags and the key strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_valid_o <= 1'b0;
            held_q      <= '0;
        end else begin
            key_valid_o <= press;
            if (press) begin
                held_q[row_idx] <= 1'b1;
            end else if (row_end && no_hit) begin
                held_q[row_idx] <= 1'b0;  // released
            end
            // several columns at once leave the flag alone
        end
    end

    // code travels with the strobe
    always_ff @(posedge clk) begin
        if (press) begin
            key_code_o <= KEY_MAP[{row_idx, col_idx}];
        end
    end

endmodule

/* keypad_top.sv */
`timescale 1ns/1ps

module keypad_top (
    input  logic                   clk,
    input  logic                   rst,
    input  keypad_pkg::col_t       columns_i,
    output keypad_pkg::row_t       rows_o,
    output display_pkg::seg_bus_t  seg_o
);
    import keypad_pkg::*;
    import display_pkg::*;

    logic        key_valid;  // one cycle per new press
    key_code_t   key_code;
    bcd_digits_t digits;
    logic        update;     // digits just changed
    bin_value_t  value;

    // producer
    keypad_scanner u_scanner (
        .clk         (clk),
        .rst         (rst),
        .columns_i   (columns_i),
        .rows_o      (rows_o),
        .key_valid_o (key_valid),
        .key_code_o  (key_code)
    );

    // buffer
    digit_entry u_entry (
        .clk         (clk),
        .rst         (rst),
        .key_valid_i (key_valid),
        .key_code_i  (key_code),
        .digits_o    (digits),
        .update_o    (update)
    );

    // consumer, conversion then display
    bin_converter u_converter (
        .clk      (clk),
        .rst      (rst),
        .start_i  (update),
        .digits_i (digits),
        .value_o  (value)
    );

    seg_display u_display (
        .clk      (clk),
        .rst      (rst),
        .value_i  (value),
        .digits_i (digits),
        .seg_o    (seg_o)
    );

endmodule

/* seg_display.sv */
`timescale 1ns/1ps

module seg_display (
    input  logic                      clk,
    input  logic                      rst,
    input  display_pkg::bin_value_t   value_i,
    input  display_pkg::bcd_digits_t  digits_i,
    output display_pkg::seg_bus_t     seg_o
);
    import display_pkg::*;

    seg_bus_t seg_next;

    // bcd on digits 3..0, hex of the value on digits 7..4
    always_comb begin
        seg_next = '0;
        for (int i = 0; i < ENTRY_DIGITS; i++) begin
            seg_next[i*7 +: 7] = HEX_GLYPH[digits_i[i*4 +: 4]];
            seg_next[(i+ENTRY_DIGITS)*7 +: 7] = HEX_GLYPH[value_i[i*4 +: 4]];
        end
    end

    // registered so the outputs never glitch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_o <= {NUM_DISPLAY_DIGITS{HEX_GLYPH[0]}};  // all zeros shown
        end else begin
            seg_o <= seg_next;
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset drops shortly after an edge, like the rest of the stimulus
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rst_o = 1'b0;
    end

endmodule

/* tb_keypad_top.sv */
`timescale 1ns/1ps

module tb_keypad_top;
    import keypad_pkg::*;
    import display_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int TOTAL_PRESSES   = 22;
    localparam int HOLD_CYCLES     = 2 * NUM_ROWS * SCAN_DIVIDE;  // two full scans
    localparam int WATCHDOG_CYCLES = (TOTAL_PRESSES * 16 + 32) * SCAN_DIVIDE;

    localparam key_code_t LETTER_KEYS [5] = '{4'hA, 4'hB, 4'hC, 4'hD, 4'hF};

    logic     clk;
    logic     rst;
    col_t     columns;
    row_t     rows;
    seg_bus_t seg;

    logic [15:0] key_down;                     // index {row, column}
    logic [3:0]  model_digits [ENTRY_DIGITS];  // digit 0 most recent
    int          seed = 15394;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    keypad_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .columns_i (columns),
        .rows_o    (rows),
        .seg_o     (seg)
    );

    // keypad matrix, a pressed key ties its row to its column
    always_comb begin
        columns = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!rows[r]) begin
                columns = columns | key_down[r*4 +: 4];
            end
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int key_index(input key_code_t code);
        for (int i = 0; i < 16; i++) begin
            if (KEY_MAP[i] == code) begin
                return i;
            end
        end
        return 0;
    endfunction

    // entry rules of the reference model
    function automatic void model_key(input key_code_t code);
        if (code <= 4'd9) begin
            for (int i = ENTRY_DIGITS - 1; i > 0; i--) begin
                model_digits[i] = model_digits[i-1];
            end
            model_digits[0] = code;
        end else if (code == KEY_CLEAR) begin
            for (int i = 0; i < ENTRY_DIGITS; i++) begin
                model_digits[i] = 4'd0;
            end
        end
    endfunction

    function automatic bcd_digits_t model_bcd();
        bcd_digits_t d;
        for (int i = 0; i < ENTRY_DIGITS; i++) begin
            d[i*4 +: 4] = model_digits[i];
        end
        return d;
    endfunction

    function automatic bin_value_t model_value();
        int v;
        v = 1000 * model_digits[3] + 100 * model_digits[2] + 10 * model_digits[1]
            + model_digits[0];
        return bin_value_t'(v);
    endfunction

    function automatic seg_bus_t build_segments(input bcd_digits_t digits,
                                                input bin_value_t value);
        seg_bus_t s;
        for (int i = 0; i < ENTRY_DIGITS; i++) begin
            s[i*7 +: 7]                  = HEX_GLYPH[digits[i*4 +: 4]];
            s[(ENTRY_DIGITS + i)*7 +: 7] = HEX_GLYPH[value[i*4 +: 4]];
        end
        return s;
    endfunction

    task automatic check_segments(input seg_bus_t actual, input seg_bus_t expected,
                                  input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s, seg_o %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_rows(input row_t actual, input row_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s, rows_o %b expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    // hold for two scans, release for two scans
    task automatic press_keys(input logic [15:0] mask);
        @(posedge clk);
        #2;
        key_down = mask;
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
        key_down = '0;
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
    endtask

    task automatic enter_key(input key_code_t code);
        press_keys(16'b1 << key_index(code));
        model_key(code);
        check_segments(seg, build_segments(model_bcd(), model_value()),
                       $sformatf("after key %h", code));
    endtask

    initial begin
        int   err_start;
        int   row;
        int   col;
        row_t expect_row;

        key_down     = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < ENTRY_DIGITS; i++) begin
            model_digits[i] = 4'd0;
        end
        @(negedge rst);

        err_start = errors;
        check_rows(rows, ROW_FIRST, "after reset");
        check_segments(seg, {NUM_DISPLAY_DIGITS{HEX_GLYPH[0]}}, "after reset");
        finish_test("reset state", err_start);

        // two rounds of the scan, checked on both sides of every row change
        err_start = errors;
        for (int r = 0; r < 2 * NUM_ROWS; r++) begin
            repeat (SCAN_DIVIDE - 1) @(posedge clk);
            #2;
            check_rows(rows, ~(row_t'(1) << (r % NUM_ROWS)), "last cycle of row");
            @(posedge clk);
            #2;
            expect_row = ~(row_t'(1) << ((r + 1) % NUM_ROWS));
            check_rows(rows, expect_row, "row change");
        end
        finish_test("row rotation", err_start);

        err_start = errors;
        enter_key(key_code_t'(1 + rand_below(9)));  // nonzero so a repeat would show
        finish_test("single held digit", err_start);

        err_start = errors;
        for (int n = 0; n < 8; n++) begin
            enter_key(key_code_t'(rand_below(10)));
        end
        for (int n = 0; n < 4; n++) begin
            enter_key(4'h9);
        end
        check_segments(seg, build_segments(16'h9999, 16'h270F), "9999 as hex 270F");
        finish_test("digit sequence", err_start);

        err_start = errors;
        enter_key(KEY_CLEAR);
        check_segments(seg, {NUM_DISPLAY_DIGITS{HEX_GLYPH[0]}}, "after clear");
        for (int n = 0; n < 2; n++) begin
            enter_key(key_code_t'(rand_below(10)));
        end
        for (int n = 0; n < 5; n++) begin
            enter_key(LETTER_KEYS[n]);  // model keeps its digits
        end
        finish_test("clear and letter keys", err_start);

        err_start = errors;
        row = rand_below(NUM_ROWS - 1);
        col = rand_below(2);
        press_keys((16'b11 << col) << (row * 4));  // two neighbouring digit keys in one row
        check_segments(seg, build_segments(model_bcd(), model_value()), "two keys in one row");
        finish_test("two keys at once", err_start);

        errors = errors + int'(dut_i.u_checker.assert_fails);
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("the run timed out before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
